// ==== hdl/isaPkg.sv ====
package isaPkg;

    localparam int WORD_SIZE = 16;

    typedef logic [WORD_SIZE-1:0] wordT;
    typedef logic [1:0] regIdxT;
    typedef logic [3:0] opcodeT;
    typedef logic [5:0] funcT;
    typedef logic [7:0] immT;

    // major opcodes in instr[15:12]
    localparam opcodeT OP_BNE = 4'd0;
    localparam opcodeT OP_BEQ = 4'd1;
    localparam opcodeT OP_ADI = 4'd4;
    localparam opcodeT OP_ORI = 4'd5;
    localparam opcodeT OP_LHI = 4'd6;
    localparam opcodeT OP_LWD = 4'd7;
    localparam opcodeT OP_SWD = 4'd8;
    localparam opcodeT OP_JMP = 4'd9;
    localparam opcodeT OP_RTYPE = 4'd15;

    // func field of R-type, instr[5:0]
    localparam funcT FN_ADD = 6'd0;
    localparam funcT FN_SUB = 6'd1;
    localparam funcT FN_AND = 6'd2;
    localparam funcT FN_ORR = 6'd3;
    localparam funcT FN_WWD = 6'd28;
    localparam funcT FN_HLT = 6'd29;

endpackage

// ==== hdl/pipePkg.sv ====
package pipePkg;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        ORR,
        PASSA,
        LHI
    } aluOpT;

    // operand source for EX
    typedef enum logic [1:0] {
        REGFILE,
        FROM_MEM,
        FROM_WB
    } fwdSelT;

    typedef struct packed {
        logic  regWrite;
        logic  memToReg;
        logic  memRead;
        logic  memWrite;
        logic  aluSrcImm;
        logic  isBranch;
        logic  branchOnEq;
        logic  isWwd;
        logic  isHalt;
        aluOpT aluOp;
    } ctrlT;

endpackage

// ==== hdl/pipeCtrlIf.sv ====
`timescale 1ns/1ps

interface pipeCtrlIf;
    import isaPkg::*;
    import pipePkg::*;

    // pipeline state seen by the control unit
    wordT   ifidInstr;
    logic   ifidValid;
    regIdxT idexRs;
    regIdxT idexRt;
    regIdxT idexRd;
    logic   idexMemRead;
    logic   idexValid;
    logic   branchTaken;
    regIdxT exmemRd;
    logic   exmemRegWrite;
    regIdxT memwbRd;
    logic   memwbRegWrite;

    // decisions made by the control unit
    ctrlT   idCtrl;
    regIdxT idRd;
    logic   stall;
    logic   flushIf;
    logic   flushId;
    logic   jumpTaken;
    fwdSelT fwdA;
    fwdSelT fwdB;

    modport dpath (
        output ifidInstr, ifidValid, idexRs, idexRt, idexRd, idexMemRead, idexValid,
        output branchTaken, exmemRd, exmemRegWrite, memwbRd, memwbRegWrite,
        input  idCtrl, idRd, stall, flushIf, flushId, jumpTaken, fwdA, fwdB
    );

    modport ctrl (
        input  ifidInstr, ifidValid, idexRs, idexRt, idexRd, idexMemRead, idexValid,
        input  branchTaken, exmemRd, exmemRegWrite, memwbRd, memwbRegWrite,
        output idCtrl, idRd, stall, flushIf, flushId, jumpTaken, fwdA, fwdB
    );

endinterface

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps

module regFile #(
    parameter int NUM_REGS = 4
) (
    input  logic           Clk,
    input  logic           rst,
    input  isaPkg::regIdxT rs,
    input  isaPkg::regIdxT rt,
    output isaPkg::wordT   rdA,
    output isaPkg::wordT   rdB,
    input  logic           we,
    input  isaPkg::regIdxT wa,
    input  isaPkg::wordT   wd
);
    import isaPkg::*;

    wordT regs [NUM_REGS];

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    // writeback in the same cycle is visible to ID
    assign rdA = (we && wa == rs) ? wd : regs[rs];
    assign rdB = (we && wa == rt) ? wd : regs[rt];

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  isaPkg::wordT   a,
    input  isaPkg::wordT   b,
    input  pipePkg::aluOpT op,
    output isaPkg::wordT   y,
    output logic           zero
);
    import pipePkg::*;

    always_comb begin
        case (op)
            ADD: begin
                y = a + b;
            end
            SUB: begin
                y = a - b;
            end
            AND: begin
                y = a & b;
            end
            ORR: begin
                y = a | b;
            end
            PASSA: begin
                y = a;
            end
            LHI: begin
                // immediate into the upper byte, low byte cleared
                y = {b[7:0], 8'h00};
            end
            default: begin
                y = '0;
            end
        endcase
    end

    // branch compare rides on SUB
    assign zero = (y == '0);

endmodule

// ==== hdl/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
    input logic     Clk,
    input logic     rst,
    pipeCtrlIf.ctrl pipe
);
    import isaPkg::*;
    import pipePkg::*;

    opcodeT opcode;
    funcT   func;
    regIdxT rs;
    regIdxT rt;
    regIdxT rd;
    logic   isRtypeAlu;
    logic   useRs;
    logic   useRt;

    function automatic fwdSelT pickFwd(regIdxT src, logic memWr, regIdxT memRd,
                                       logic wbWr, regIdxT wbRd);
        if (memWr && memRd == src) begin
            return FROM_MEM;
        end
        if (wbWr && wbRd == src) begin
            return FROM_WB;
        end
        return REGFILE;
    endfunction

    assign opcode = pipe.ifidInstr[15:12];
    assign rs = pipe.ifidInstr[11:10];
    assign rt = pipe.ifidInstr[9:8];
    assign rd = pipe.ifidInstr[7:6];
    assign func = pipe.ifidInstr[5:0];
    assign isRtypeAlu = (opcode == OP_RTYPE) && (func inside {FN_ADD, FN_SUB, FN_AND, FN_ORR});

    always_comb begin
        pipe.idCtrl = '0;
        pipe.idCtrl.aluOp = ADD;
        if (pipe.ifidValid) begin
            case (opcode)
                OP_RTYPE: begin
                    pipe.idCtrl.regWrite = isRtypeAlu;
                    pipe.idCtrl.isWwd = (func == FN_WWD);
                    pipe.idCtrl.isHalt = (func == FN_HLT);
                    case (func)
                        FN_SUB:  pipe.idCtrl.aluOp = SUB;
                        FN_AND:  pipe.idCtrl.aluOp = AND;
                        FN_ORR:  pipe.idCtrl.aluOp = ORR;
                        FN_WWD:  pipe.idCtrl.aluOp = PASSA;
                        default: pipe.idCtrl.aluOp = ADD;
                    endcase
                end
                OP_ADI: begin
                    pipe.idCtrl.regWrite = 1'b1;
                    pipe.idCtrl.aluSrcImm = 1'b1;
                end
                OP_ORI: begin
                    pipe.idCtrl.regWrite = 1'b1;
                    pipe.idCtrl.aluSrcImm = 1'b1;
                    pipe.idCtrl.aluOp = ORR;
                end
                OP_LHI: begin
                    pipe.idCtrl.regWrite = 1'b1;
                    pipe.idCtrl.aluSrcImm = 1'b1;
                    pipe.idCtrl.aluOp = LHI;
                end
                OP_LWD: begin
                    pipe.idCtrl.regWrite = 1'b1;
                    pipe.idCtrl.memToReg = 1'b1;
                    pipe.idCtrl.memRead = 1'b1;
                    pipe.idCtrl.aluSrcImm = 1'b1;
                end
                OP_SWD: begin
                    pipe.idCtrl.memWrite = 1'b1;
                    pipe.idCtrl.aluSrcImm = 1'b1;
                end
                OP_BNE, OP_BEQ: begin
                    pipe.idCtrl.isBranch = 1'b1;
                    pipe.idCtrl.branchOnEq = (opcode == OP_BEQ);
                    pipe.idCtrl.aluOp = SUB;
                end
                default: begin
                end
            endcase
        end
    end

    // R-type writes rd, everything else writes rt
    assign pipe.idRd = (opcode == OP_RTYPE) ? rd : rt;

    assign useRs = pipe.ifidValid && !(opcode inside {OP_JMP, OP_LHI})
                   && !(opcode == OP_RTYPE && func == FN_HLT);
    assign useRt = pipe.ifidValid && (isRtypeAlu || opcode inside {OP_SWD, OP_BNE, OP_BEQ});

    // load in EX feeding the instruction in ID
    assign pipe.stall = pipe.idexValid && pipe.idexMemRead
                        && ((useRs && pipe.idexRd == rs) || (useRt && pipe.idexRd == rt));

    assign pipe.jumpTaken = pipe.ifidValid && (opcode == OP_JMP);
    assign pipe.flushIf = pipe.branchTaken || pipe.jumpTaken;
    assign pipe.flushId = pipe.branchTaken;

    assign pipe.fwdA = pickFwd(pipe.idexRs, pipe.exmemRegWrite, pipe.exmemRd,
                               pipe.memwbRegWrite, pipe.memwbRd);
    assign pipe.fwdB = pickFwd(pipe.idexRt, pipe.exmemRegWrite, pipe.exmemRd,
                               pipe.memwbRegWrite, pipe.memwbRd);

    // the instruction in EX is never both a resolving branch and a stalling load
    assert property (@(posedge Clk) disable iff (rst)
        !(pipe.flushId && pipe.stall));

endmodule

// ==== hdl/datapath.sv ====
`timescale 1ns/1ps

module datapath #(
    parameter int NUM_REGS = 4
) (
    input  logic          Clk,
    input  logic          rst,
    pipeCtrlIf.dpath      pipe,
    output isaPkg::wordT  instrAddr,
    input  isaPkg::wordT  instrData,
    output isaPkg::wordT  dataAddr,
    output logic          dataRead,
    output logic          dataWrite,
    output isaPkg::wordT  dataOut,
    input  isaPkg::wordT  dataIn,
    output isaPkg::wordT  outputPort,
    output logic          outputValid,
    output logic          halted,
    output isaPkg::wordT  numInst
);
    import isaPkg::*;
    import pipePkg::*;

    wordT pc;
    wordT ifidPc;
    wordT idexPc;
    wordT idexA;
    wordT idexB;
    wordT idexImm;
    ctrlT idexCtrl;
    wordT exmemAlu;
    wordT exmemStore;
    ctrlT exmemCtrl;
    logic exmemValid;
    wordT memwbAlu;
    wordT memwbMem;
    ctrlT memwbCtrl;
    logic memwbValid;

    immT  immField;
    wordT idImm;
    wordT rfA;
    wordT rfB;
    wordT opA;
    wordT opB;
    wordT aluY;
    logic aluZero;
    wordT wbData;
    logic drain;

    function automatic wordT fwdMux(fwdSelT sel, wordT fromReg, wordT fromMem, wordT fromWb);
        case (sel)
            FROM_MEM: return fromMem;
            FROM_WB:  return fromWb;
            default:  return fromReg;
        endcase
    endfunction

    regFile #(.NUM_REGS(NUM_REGS)) rf (
        .Clk(Clk),
        .rst(rst),
        .rs(pipe.ifidInstr[11:10]),
        .rt(pipe.ifidInstr[9:8]),
        .rdA(rfA),
        .rdB(rfB),
        .we(pipe.memwbRegWrite),
        .wa(pipe.memwbRd),
        .wd(wbData)
    );

    // ORI zero-extends, the rest sign-extend
    assign immField = pipe.ifidInstr[7:0];
    assign idImm = (pipe.ifidInstr[15:12] == OP_ORI) ? {8'h00, immField}
                                                     : {{8{immField[7]}}, immField};

    // once a HLT is past ID nothing younger may issue
    assign drain = halted || (pipe.idexValid && idexCtrl.isHalt)
                   || (exmemValid && exmemCtrl.isHalt) || (memwbValid && memwbCtrl.isHalt);

    assign opA = fwdMux(pipe.fwdA, idexA, exmemAlu, wbData);
    assign opB = fwdMux(pipe.fwdB, idexB, exmemAlu, wbData);

    alu exAlu (
        .a(opA),
        .b(idexCtrl.aluSrcImm ? idexImm : opB),
        .op(idexCtrl.aluOp),
        .y(aluY),
        .zero(aluZero)
    );

    assign pipe.branchTaken = pipe.idexValid && idexCtrl.isBranch
                              && (aluZero == idexCtrl.branchOnEq);
    assign pipe.idexMemRead = idexCtrl.memRead;
    assign pipe.exmemRegWrite = exmemValid && exmemCtrl.regWrite;
    assign pipe.memwbRegWrite = memwbValid && memwbCtrl.regWrite;

    always_ff @(posedge Clk) begin
        if (rst) begin
            pc <= '0;
        end else if (pipe.branchTaken) begin
            pc <= idexPc + 1'b1 + idexImm;
        end else if (pipe.jumpTaken) begin
            pc <= {ifidPc[15:12], pipe.ifidInstr[11:0]};
        end else if (!(pipe.stall || drain)) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (rst || pipe.flushIf || drain) begin
            pipe.ifidValid <= 1'b0;
        end else if (!pipe.stall) begin
            pipe.ifidValid <= 1'b1;
            pipe.ifidInstr <= instrData;
            ifidPc <= pc;
        end
    end

    always_ff @(posedge Clk) begin
        if (rst || pipe.flushId || pipe.stall || drain) begin
            pipe.idexValid <= 1'b0;
        end else begin
            pipe.idexValid <= pipe.ifidValid;
        end
        if (rst) begin
            exmemValid <= 1'b0;
            memwbValid <= 1'b0;
        end else begin
            exmemValid <= pipe.idexValid;
            memwbValid <= exmemValid;
        end
    end

    always_ff @(posedge Clk) begin
        idexPc <= ifidPc;
        idexA <= rfA;
        idexB <= rfB;
        idexImm <= idImm;
        idexCtrl <= pipe.idCtrl;
        pipe.idexRs <= pipe.ifidInstr[11:10];
        pipe.idexRt <= pipe.ifidInstr[9:8];
        pipe.idexRd <= pipe.idRd;
        exmemAlu <= aluY;
        exmemStore <= opB;
        exmemCtrl <= idexCtrl;
        pipe.exmemRd <= pipe.idexRd;
        memwbAlu <= exmemAlu;
        memwbMem <= dataIn;
        memwbCtrl <= exmemCtrl;
        pipe.memwbRd <= pipe.exmemRd;
    end

    // retirement
    always_ff @(posedge Clk) begin
        if (rst) begin
            halted <= 1'b0;
            numInst <= '0;
        end else if (memwbValid && !halted) begin
            numInst <= numInst + 1'b1;
            if (memwbCtrl.isHalt) begin
                halted <= 1'b1;
            end
        end
    end

    assign wbData = memwbCtrl.memToReg ? memwbMem : memwbAlu;
    assign outputPort = memwbAlu;
    assign outputValid = memwbValid && memwbCtrl.isWwd;

    assign instrAddr = pc;
    assign dataAddr = exmemAlu;
    assign dataOut = exmemStore;
    assign dataRead = exmemValid && exmemCtrl.memRead;
    assign dataWrite = exmemValid && exmemCtrl.memWrite;

    // once halted, fetch stays frozen
    assert property (@(posedge Clk) disable iff (rst) halted |=> halted && $stable(pc));
    assert property (@(posedge Clk) disable iff (rst) !(dataRead && dataWrite));

endmodule

// ==== hdl/cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore #(
    parameter int NUM_REGS = 4
) (
    input  logic         Clk,
    input  logic         rst,
    output isaPkg::wordT instrAddr,
    input  isaPkg::wordT instrData,
    output isaPkg::wordT dataAddr,
    output logic         dataRead,
    output logic         dataWrite,
    output isaPkg::wordT dataOut,
    input  isaPkg::wordT dataIn,
    output isaPkg::wordT outputPort,
    output logic         outputValid,
    output logic         halted,
    output isaPkg::wordT numInst
);

    pipeCtrlIf pipe ();

    controlUnit ctrlUnit (
        .Clk(Clk),
        .rst(rst),
        .pipe(pipe.ctrl)
    );

    datapath #(.NUM_REGS(NUM_REGS)) dataPath (
        .Clk(Clk),
        .rst(rst),
        .pipe(pipe.dpath),
        .instrAddr(instrAddr),
        .instrData(instrData),
        .dataAddr(dataAddr),
        .dataRead(dataRead),
        .dataWrite(dataWrite),
        .dataOut(dataOut),
        .dataIn(dataIn),
        .outputPort(outputPort),
        .outputValid(outputValid),
        .halted(halted),
        .numInst(numInst)
    );

endmodule

// ==== tests/tbProgram.svh ====
// fixed program skeleton, immediates drawn from the xorshift stream
task automatic buildProgram();
    immT addrOfs;
    for (int i = 0; i < ROM_DEPTH; i++) begin
        rom[i] = HALT_WORD;
    end
    addrOfs = nextImm();
    rom[0] = immWord(OP_LHI, 2'd0, 2'd1, nextImm());
    rom[1] = rtypeWord(2'd1, 2'd0, 2'd0, FN_WWD);
    // dependent chain, forwarded from both MEM and WB
    rom[2] = immWord(OP_ADI, 2'd0, 2'd2, nextImm());
    rom[3] = immWord(OP_ORI, 2'd2, 2'd3, nextImm());
    rom[4] = rtypeWord(2'd2, 2'd3, 2'd0, FN_ADD);
    rom[5] = rtypeWord(2'd0, 2'd2, 2'd1, FN_SUB);
    rom[6] = rtypeWord(2'd1, 2'd3, 2'd2, FN_AND);
    rom[7] = rtypeWord(2'd2, 2'd0, 2'd3, FN_ORR);
    rom[8] = rtypeWord(2'd3, 2'd0, 2'd0, FN_WWD);
    // store, load back, use at once
    rom[9] = immWord(OP_SWD, 2'd1, 2'd3, addrOfs);
    rom[10] = immWord(OP_LWD, 2'd1, 2'd0, addrOfs);
    rom[11] = rtypeWord(2'd0, 2'd0, 2'd0, FN_WWD);
    // branches and a jump, each skipped slot holds a WWD
    rom[12] = immWord(OP_BEQ, 2'd0, 2'd3, 8'd1);
    rom[13] = rtypeWord(2'd1, 2'd0, 2'd0, FN_WWD);
    rom[14] = immWord(OP_BNE, 2'd0, 2'd3, 8'd1);
    rom[15] = rtypeWord(2'd2, 2'd0, 2'd0, FN_WWD);
    // r1 and r2 are equal after the chain, step r2 off by one
    rom[16] = immWord(OP_ADI, 2'd2, 2'd2, 8'd1);
    rom[17] = immWord(OP_BEQ, 2'd1, 2'd2, 8'd1);
    rom[18] = rtypeWord(2'd2, 2'd0, 2'd0, FN_WWD);
    rom[19] = immWord(OP_BNE, 2'd1, 2'd2, 8'd1);
    rom[20] = rtypeWord(2'd0, 2'd0, 2'd0, FN_WWD);
    rom[21] = jumpWord(12'd23);
    rom[22] = rtypeWord(2'd3, 2'd0, 2'd0, FN_WWD);
    rom[23] = immWord(OP_ADI, 2'd1, 2'd1, nextImm());
    rom[24] = rtypeWord(2'd1, 2'd0, 2'd0, FN_WWD);
    rom[25] = HALT_WORD;
endtask

// ==== tests/cpuCoreTb.sv ====
`timescale 1ns/1ps

module cpuCoreTb;
    import isaPkg::*;

    localparam int ROM_DEPTH = 32;
    localparam wordT HALT_WORD = {OP_RTYPE, 6'd0, FN_HLT};

    logic Clk;
    logic rst;
    wordT instrAddr;
    wordT instrData;
    wordT dataAddr;
    logic dataRead;
    logic dataWrite;
    wordT dataOut;
    wordT dataIn;
    wordT outputPort;
    logic outputValid;
    logic halted;
    wordT numInst;

    wordT rom [ROM_DEPTH];
    wordT ram [65536];
    wordT modelMem [65536];
    wordT expOuts [$];
    int outIdx;
    int expRetired;
    logic [31:0] rngState;

    cpuCore #(.NUM_REGS(4)) uut (.*);

    always #10 Clk = ~Clk;

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic immT nextImm();
        rngState = xorshift(rngState);
        return rngState[7:0];
    endfunction

    function automatic wordT rtypeWord(regIdxT rs, regIdxT rt, regIdxT rd, funcT fn);
        return {OP_RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic wordT immWord(opcodeT op, regIdxT rs, regIdxT rt, immT imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT jumpWord(logic [11:0] target);
        return {OP_JMP, target};
    endfunction

    // odd multiplier keeps every address bit in play
    function automatic wordT ramFill(logic [31:0] addr);
        logic [31:0] p;
        p = addr * 32'd40503;
        return p[15:0] ^ 16'hc3a5;
    endfunction

    // anything past the program halts
    function automatic wordT romWord(wordT addr);
        return (addr < ROM_DEPTH) ? rom[addr] : HALT_WORD;
    endfunction

    `include "tbProgram.svh"

    // one instruction at a time, fills expOuts and returns the retire count
    function automatic int runModel();
        wordT regs [4];
        wordT pc;
        wordT instr;
        wordT nextPc;
        wordT sImm;
        regIdxT rs;
        regIdxT rt;
        regIdxT rd;
        int steps;
        logic done;
        for (int i = 0; i < 4; i++) begin
            regs[i] = '0;
        end
        pc = '0;
        steps = 0;
        done = 1'b0;
        expOuts.delete();
        while (!done && steps < 1000) begin
            instr = romWord(pc);
            rs = instr[11:10];
            rt = instr[9:8];
            rd = instr[7:6];
            sImm = {{8{instr[7]}}, instr[7:0]};
            nextPc = pc + 16'd1;
            steps++;
            case (opcodeT'(instr[15:12]))
                OP_RTYPE: begin
                    case (funcT'(instr[5:0]))
                        FN_ADD: regs[rd] = regs[rs] + regs[rt];
                        FN_SUB: regs[rd] = regs[rs] - regs[rt];
                        FN_AND: regs[rd] = regs[rs] & regs[rt];
                        FN_ORR: regs[rd] = regs[rs] | regs[rt];
                        FN_WWD: expOuts.push_back(regs[rs]);
                        FN_HLT: done = 1'b1;
                        default: begin
                        end
                    endcase
                end
                OP_ADI: regs[rt] = regs[rs] + sImm;
                OP_ORI: regs[rt] = regs[rs] | {8'h00, instr[7:0]};
                OP_LHI: regs[rt] = {instr[7:0], 8'h00};
                OP_LWD: regs[rt] = modelMem[regs[rs] + sImm];
                OP_SWD: modelMem[regs[rs] + sImm] = regs[rt];
                OP_BNE: begin
                    if (regs[rs] != regs[rt]) begin
                        nextPc = pc + 16'd1 + sImm;
                    end
                end
                OP_BEQ: begin
                    if (regs[rs] == regs[rt]) begin
                        nextPc = pc + 16'd1 + sImm;
                    end
                end
                OP_JMP: nextPc = {pc[15:12], instr[11:0]};
                default: begin
                end
            endcase
            pc = nextPc;
        end
        return steps;
    endfunction

    task automatic abortRun();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkWord(string name, wordT got, wordT exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            abortRun();
        end
    endtask

    // combinational memories, presented to the core on the falling edge
    // the data bus idles at zero outside a read strobe
    always @(negedge Clk) begin
        instrData <= romWord(instrAddr);
        dataIn <= dataRead ? ram[dataAddr] : '0;
    end

    always @(posedge Clk) begin
        if (dataWrite) begin
            ram[dataAddr] <= dataOut;
        end
    end

    // WWD results against the model, in order
    always @(negedge Clk) begin
        if (!rst && outputValid) begin
            if (outIdx >= expOuts.size()) begin
                $display("outputValid pulsed with no WWD value left in the model");
                abortRun();
            end else begin
                checkWord("outputPort", outputPort, expOuts[outIdx]);
                outIdx++;
            end
        end
    end

    initial begin
        repeat (ROM_DEPTH * 8 + 50) @(posedge Clk);
        $display("watchdog expired before the core halted");
        abortRun();
    end

    initial begin
        Clk = 1'b0;
        rst = 1'b1;
        instrData = '0;
        dataIn = '0;
        outIdx = 0;
        rngState = 32'h9858_ac99;
        buildProgram();
        for (int i = 0; i < 65536; i++) begin
            ram[i] = ramFill(i);
            modelMem[i] = ramFill(i);
        end
        expRetired = runModel();
        repeat (2) @(negedge Clk);
        rst = 1'b0;
        checkFlag("halted", halted, 1'b0);
        checkFlag("outputValid", outputValid, 1'b0);
        checkFlag("dataRead", dataRead, 1'b0);
        checkFlag("dataWrite", dataWrite, 1'b0);
        checkWord("numInst", numInst, '0);
        while (halted !== 1'b1) begin
            @(negedge Clk);
        end
        checkWord("numInst", numInst, wordT'(expRetired));
        if (outIdx != expOuts.size()) begin
            $display("core halted with %0d of %0d WWD values seen", outIdx, expOuts.size());
            abortRun();
        end
        // halted and numInst stay frozen
        repeat (20) begin
            @(negedge Clk);
            checkFlag("halted", halted, 1'b1);
            checkWord("numInst", numInst, wordT'(expRetired));
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== cpuCore.f ====
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/pipeCtrlIf.sv
hdl/regFile.sv
hdl/alu.sv
hdl/controlUnit.sv
hdl/datapath.sv
hdl/cpuCore.sv
+incdir+tests
tests/cpuCoreTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module cpuCoreTb -f cpuCore.f -o simCpuCore &&
./obj_dir/simCpuCore | tee /dev/stderr | grep -q "Simulation completed successfully" &&
echo "PASS" || { echo "FAIL"; exit 1; }
